// File: ex_stage.f
hw/ex_pkg.sv
hw/ex_stage_reg.sv
hw/ex_alu.sv
hw/ex_branch.sv
hw/ex_lsu.sv
hw/ex_stage.sv
verification/ex_stage_chk.sv
verification/ex_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ex_stage_tb -f ex_stage.f

output=$(./obj_dir/Vex_stage_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: verification/ex_stage_tb.sv
// testbench for the execute stage with random stimulus and a reference model
`timescale 1ns/1ps
module ex_stage_tb
    import ex_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int N_INSTR = 600;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     oper1;
        word_t     oper2;
        word_t     pass_data;
        word_t     rj;
        word_t     rk;
        word_t     offs;
        wb_sel_e   wb_sel;
        br_type_e  br;
        logic      mreq;
        logic      mwe;
        mem_size_e msize;
        logic      rwe;
        reg_addr_t waddr;
        logic      excep;
    } instr_t;

    typedef struct packed {
        word_t  wdata;
        logic   mreq;
        logic   rwe;
        logic   ale;
        logic   excep;
        logic   req;
        logic   we;
        word_t  addr;
        wstrb_t strb;
        word_t  mdata;
        logic   flush;
        word_t  jaddr;
    } expect_t;

    logic      clk;
    logic      rst_i;
    logic      in_valid_i;
    word_t     pc_i;
    alu_op_e   alu_op_i;
    word_t     oper1_i;
    word_t     oper2_i;
    word_t     pass_data_i;
    word_t     rj_data_i;
    word_t     rk_data_i;
    word_t     jmp_offs_i;
    wb_sel_e   wb_sel_i;
    br_type_e  br_type_i;
    logic      mem_req_i;
    logic      mem_we_i;
    mem_size_e mem_size_i;
    logic      regs_we_i;
    reg_addr_t regs_waddr_i;
    logic      excep_i;
    logic      excep_flush_i;
    logic      next_allowin_i;
    logic      mem_addr_ok_i;
    logic      allowin_o;
    logic      out_valid_o;
    word_t     out_pc_o;
    logic      regs_we_o;
    reg_addr_t regs_waddr_o;
    word_t     regs_wdata_o;
    logic      excep_o;
    logic      ale_o;
    logic      mem_req_o;
    logic      mem_we_o;
    word_t     mem_addr_o;
    wstrb_t    mem_wstrb_o;
    word_t     mem_wdata_o;
    logic      branch_flush_o;
    word_t     jmp_addr_o;

    word_t  seed;
    instr_t pending[$];
    int     departed;
    int     flushed;

    ex_stage dut (.*);

    bind ex_stage ex_stage_chk u_chk (
        .clk(clk), .rst_i(rst_i), .out_valid_i(out_valid_o), .excep_flush_i(excep_flush_i),
        .mem_req_i(mem_req_o), .mem_we_i(mem_we_o), .mem_wstrb_i(mem_wstrb_o),
        .ale_i(ale_o), .excep_i(excep_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic word_t next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    // sign boundaries show up about a third of the time
    function automatic word_t pick_operand();
        word_t r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return 32'h7fff_ffff;
            3'd1:    return 32'h8000_0000;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return r[3] ? 32'd1 : 32'd0;
            default: return next_rand();
        endcase
    endfunction

    function automatic instr_t sample_inputs();
        instr_t in;
        in.pc        = pc_i;
        in.alu_op    = alu_op_i;
        in.oper1     = oper1_i;
        in.oper2     = oper2_i;
        in.pass_data = pass_data_i;
        in.rj        = rj_data_i;
        in.rk        = rk_data_i;
        in.offs      = jmp_offs_i;
        in.wb_sel    = wb_sel_i;
        in.br        = br_type_i;
        in.mreq      = mem_req_i;
        in.mwe       = mem_we_i;
        in.msize     = mem_size_i;
        in.rwe       = regs_we_i;
        in.waddr     = regs_waddr_i;
        in.excep     = excep_i;
        return in;
    endfunction

    function automatic expect_t ref_model(instr_t in);
        expect_t     e;
        word_t       alu;
        logic [63:0] prod;
        logic        mis;
        logic        taken;
        e = '0;
        prod = '0;
        case (in.alu_op)
            ALU_ADD:  alu = in.oper1 + in.oper2;
            ALU_SUB:  alu = in.oper1 - in.oper2;
            ALU_SLT:  alu = ($signed(in.oper1) < $signed(in.oper2)) ? 32'd1 : 32'd0;
            ALU_SLTU: alu = (in.oper1 < in.oper2) ? 32'd1 : 32'd0;
            ALU_AND:  alu = in.oper1 & in.oper2;
            ALU_OR:   alu = in.oper1 | in.oper2;
            ALU_NOR:  alu = ~(in.oper1 | in.oper2);
            ALU_XOR:  alu = in.oper1 ^ in.oper2;
            ALU_SLL:  alu = in.oper1 << in.oper2[4:0];
            ALU_SRL:  alu = in.oper1 >> in.oper2[4:0];
            ALU_SRA:  alu = word_t'($signed(in.oper1) >>> in.oper2[4:0]);
            ALU_MUL:  alu = in.oper1 * in.oper2;
            ALU_MULH: begin
                prod = {{32{in.oper1[31]}}, in.oper1} * {{32{in.oper2[31]}}, in.oper2};
                alu = prod[63:32];
            end
            ALU_MULHU: begin
                prod = {32'd0, in.oper1} * {32'd0, in.oper2};
                alu = prod[63:32];
            end
            default:  alu = '0;
        endcase
        e.wdata = (in.wb_sel == WB_ALU) ? alu : in.pass_data;
        case (in.msize)
            MEM_BYTE: begin
                mis = 1'b0;
                e.strb = wstrb_t'(4'b0001 << alu[1:0]);
                e.mdata = {4{in.rk[7:0]}};
            end
            MEM_HALF: begin
                mis = alu[0];
                e.strb = alu[1] ? 4'b1100 : 4'b0011;
                e.mdata = {2{in.rk[15:0]}};
            end
            default: begin
                mis = |alu[1:0];
                e.strb = 4'b1111;
                e.mdata = in.rk;
            end
        endcase
        e.mreq  = in.mreq;
        e.ale   = in.mreq & mis;
        e.excep = in.excep | e.ale;
        e.rwe   = in.rwe & ~e.excep;
        e.req   = in.mreq & ~e.excep;
        e.we    = e.req & in.mwe;
        e.addr  = in.mreq ? alu : '0;
        case (in.br)
            BR_BEQ:  taken = (in.rj == in.rk);
            BR_BNE:  taken = (in.rj != in.rk);
            BR_BLT:  taken = ($signed(in.rj) < $signed(in.rk));
            BR_BGE:  taken = ($signed(in.rj) >= $signed(in.rk));
            BR_BLTU: taken = (in.rj < in.rk);
            BR_BGEU: taken = (in.rj >= in.rk);
            BR_B,
            BR_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        e.flush = taken & ~e.excep;
        e.jaddr = ((in.br == BR_JIRL) ? in.rj : in.pc) + in.offs;
        return e;
    endfunction

    task automatic expect_equal(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h at %0t", name, expected, actual, $time);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    // scoreboard, outputs sampled before the edge updates anything
    always @(posedge clk) begin : compare_proc
        expect_t e;
        logic    occ;
        logic    live;
        logic    ready;
        logic    exp_valid;
        logic    leave;
        logic    exp_allowin;
        logic    wr_now;
        if (!rst_i) begin
            occ = (pending.size() != 0);
            if (occ)
                e = ref_model(pending[0]);
            else
                e = '0;
            live = occ & ~excep_flush_i;
            ready = ~e.mreq | e.excep | (next_allowin_i & mem_addr_ok_i);
            exp_valid = live & ready;
            leave = exp_valid & next_allowin_i;
            exp_allowin = ~excep_flush_i & (~occ | leave);
            wr_now = live & e.we & next_allowin_i;
            expect_equal("allowin_o", exp_allowin, allowin_o);
            expect_equal("out_valid_o", exp_valid, out_valid_o);
            expect_equal("mem_req_o", live & e.req & next_allowin_i, mem_req_o);
            expect_equal("mem_we_o", wr_now, mem_we_o);
            expect_equal("mem_wstrb_o", wr_now ? e.strb : 4'b0000, mem_wstrb_o);
            expect_equal("excep_o", live & e.excep, excep_o);
            expect_equal("ale_o", live & e.ale, ale_o);
            expect_equal("regs_we_o", live & e.rwe, regs_we_o);
            expect_equal("branch_flush_o", live & e.flush, branch_flush_o);
            if (leave) begin
                expect_equal("regs_wdata_o", e.wdata, regs_wdata_o);
                expect_equal("regs_waddr_o", pending[0].waddr, regs_waddr_o);
                expect_equal("out_pc_o", pending[0].pc, out_pc_o);
                expect_equal("mem_addr_o", e.addr, mem_addr_o);
                expect_equal("jmp_addr_o", e.flush ? e.jaddr : 32'd0, jmp_addr_o);
                if (e.we)
                    expect_equal("mem_wdata_o", e.mdata, mem_wdata_o);
                void'(pending.pop_front());
                departed++;
            end else if (excep_flush_i && occ) begin
                void'(pending.pop_front());
                flushed++;
            end
            if (in_valid_i && exp_allowin)
                pending.push_back(sample_inputs());
        end
    end

    initial begin
        #(CLK_PERIOD * (N_INSTR * 20 + RESET_CYCLES));
        $display("watchdog expired with %0d of %0d instructions retired",
                 departed + flushed, N_INSTR);
        $display("Finished with errors");
        $fatal(1, "simulation timed out");
    end

    initial begin : stimulus
        word_t      r;
        word_t      rj;
        logic [1:0] kind;
        seed = 32'had2a;
        departed = 0;
        flushed = 0;
        rst_i = 1'b1;
        in_valid_i = 1'b0;
        pc_i = '0;
        alu_op_i = ALU_ADD;
        oper1_i = '0;
        oper2_i = '0;
        pass_data_i = '0;
        rj_data_i = '0;
        rk_data_i = '0;
        jmp_offs_i = '0;
        wb_sel_i = WB_ALU;
        br_type_i = BR_NONE;
        mem_req_i = 1'b0;
        mem_we_i = 1'b0;
        mem_size_i = MEM_WORD;
        regs_we_i = 1'b0;
        regs_waddr_i = '0;
        excep_i = 1'b0;
        excep_flush_i = 1'b0;
        next_allowin_i = 1'b0;
        mem_addr_ok_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        while (departed + flushed < N_INSTR) begin
            r = next_rand();
            kind = r[1:0];
            rj = pick_operand();
            in_valid_i     <= r[2] | r[3];
            next_allowin_i <= r[4] | r[5];
            mem_addr_ok_i  <= r[6] | r[7];
            excep_flush_i  <= (r[12:8] == 5'd0);
            excep_i        <= (r[16:13] == 4'd0);
            wb_sel_i       <= wb_sel_e'(r[17]);
            regs_we_i      <= r[18];
            mem_we_i       <= r[19];
            regs_waddr_i   <= r[24:20];
            mem_size_i     <= mem_size_e'(2'(r[26:25] % 3));
            rj_data_i      <= rj;
            rk_data_i      <= r[27] ? rj : pick_operand();
            pc_i           <= next_rand() & 32'hffff_fffc;
            oper1_i        <= pick_operand();
            pass_data_i    <= next_rand();
            jmp_offs_i     <= next_rand();
            case (kind)
                // memory op, base plus a small offset hits every byte lane
                2'd0: begin
                    alu_op_i  <= ALU_ADD;
                    oper2_i   <= next_rand() % 16;
                    mem_req_i <= 1'b1;
                    br_type_i <= BR_NONE;
                end
                2'd1: begin
                    alu_op_i  <= alu_op_e'(4'(next_rand() % 14));
                    oper2_i   <= pick_operand();
                    mem_req_i <= 1'b0;
                    br_type_i <= br_type_e'(4'(1 + next_rand() % 8));
                end
                default: begin
                    alu_op_i  <= alu_op_e'(4'(next_rand() % 14));
                    oper2_i   <= pick_operand();
                    mem_req_i <= 1'b0;
                    br_type_i <= BR_NONE;
                end
            endcase
            @(posedge clk);
        end
        // drain whatever is still in the stage
        in_valid_i     <= 1'b0;
        excep_flush_i  <= 1'b0;
        next_allowin_i <= 1'b1;
        mem_addr_ok_i  <= 1'b1;
        while (pending.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
        if (departed == 0) begin
            $display("no instruction ever left the stage");
            $display("Finished with errors");
            $fatal(1, "no departures");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: verification/ex_stage_chk.sv
// execute stage assertions on the handshake and memory request rules
`timescale 1ns/1ps
module ex_stage_chk
    import ex_pkg::*;
(
    input logic   clk,
    input logic   rst_i,
    input logic   out_valid_i,
    input logic   excep_flush_i,
    input logic   mem_req_i,
    input logic   mem_we_i,
    input wstrb_t mem_wstrb_i,
    input logic   ale_i,
    input logic   excep_i
);

    // a faulting access never reaches the bus
    a_req_no_excep: assert property (@(posedge clk) disable iff (rst_i)
        mem_req_i |-> !(ale_i || excep_i))
        else $error("memory request raised while an exception is pending");

    a_strobe_we: assert property (@(posedge clk) disable iff (rst_i)
        (mem_wstrb_i != '0) |-> mem_we_i)
        else $error("byte strobes active without a write");

    // flush kills the occupant in the same cycle
    a_flush_kill: assert property (@(posedge clk) disable iff (rst_i)
        !(out_valid_i && excep_flush_i))
        else $error("out_valid_o high during a flush");

    a_reset_empty: assert property (@(posedge clk) rst_i |=> !out_valid_i)
        else $error("out_valid_o high right after reset");

endmodule

// File: hw/ex_stage.sv
// execute stage top joining the latch, ALU, branch unit and LSU
`timescale 1ns/1ps
module ex_stage
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      in_valid_i,
    input  word_t     pc_i,
    input  alu_op_e   alu_op_i,
    input  word_t     oper1_i,
    input  word_t     oper2_i,
    input  word_t     pass_data_i,
    input  word_t     rj_data_i,
    input  word_t     rk_data_i,
    input  word_t     jmp_offs_i,
    input  wb_sel_e   wb_sel_i,
    input  br_type_e  br_type_i,
    input  logic      mem_req_i,
    input  logic      mem_we_i,
    input  mem_size_e mem_size_i,
    input  logic      regs_we_i,
    input  reg_addr_t regs_waddr_i,
    input  logic      excep_i,
    input  logic      excep_flush_i,
    input  logic      next_allowin_i,
    input  logic      mem_addr_ok_i,
    output logic      allowin_o,
    output logic      out_valid_o,
    output word_t     out_pc_o,
    output logic      regs_we_o,
    output reg_addr_t regs_waddr_o,
    output word_t     regs_wdata_o,
    output logic      excep_o,
    output logic      ale_o,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output word_t     mem_addr_o,
    output wstrb_t    mem_wstrb_o,
    output word_t     mem_wdata_o,
    output logic      branch_flush_o,
    output word_t     jmp_addr_o
);

    logic      ctl_valid;
    logic      ready_go;
    alu_op_e   l_alu_op;
    word_t     l_oper1;
    word_t     l_oper2;
    word_t     l_pass_data;
    word_t     l_rj_data;
    word_t     l_rk_data;
    word_t     l_jmp_offs;
    wb_sel_e   l_wb_sel;
    br_type_e  l_br_type;
    logic      l_mem_req;
    logic      l_mem_we;
    mem_size_e l_mem_size;
    word_t     alu_result;

    ex_stage_reg u_reg (
        .clk(clk), .rst_i(rst_i), .in_valid_i(in_valid_i),
        .pc_i(pc_i), .alu_op_i(alu_op_i), .oper1_i(oper1_i), .oper2_i(oper2_i),
        .pass_data_i(pass_data_i), .rj_data_i(rj_data_i), .rk_data_i(rk_data_i),
        .jmp_offs_i(jmp_offs_i), .wb_sel_i(wb_sel_i), .br_type_i(br_type_i),
        .mem_req_i(mem_req_i), .mem_we_i(mem_we_i), .mem_size_i(mem_size_i),
        .regs_we_i(regs_we_i), .regs_waddr_i(regs_waddr_i), .excep_i(excep_i),
        .excep_flush_i(excep_flush_i), .next_allowin_i(next_allowin_i),
        .ready_go_i(ready_go), .ale_i(ale_o),
        .allowin_o(allowin_o), .out_valid_o(out_valid_o), .ctl_valid_o(ctl_valid),
        .pc_o(out_pc_o), .alu_op_o(l_alu_op), .oper1_o(l_oper1), .oper2_o(l_oper2),
        .pass_data_o(l_pass_data), .rj_data_o(l_rj_data), .rk_data_o(l_rk_data),
        .jmp_offs_o(l_jmp_offs), .wb_sel_o(l_wb_sel), .br_type_o(l_br_type),
        .mem_req_o(l_mem_req), .mem_we_o(l_mem_we), .mem_size_o(l_mem_size),
        .regs_waddr_o(regs_waddr_o), .excep_o(excep_o), .regs_we_o(regs_we_o)
    );

    ex_alu u_alu (
        .alu_op_i(l_alu_op), .oper1_i(l_oper1), .oper2_i(l_oper2),
        .pass_data_i(l_pass_data), .wb_sel_i(l_wb_sel),
        .alu_result_o(alu_result), .regs_wdata_o(regs_wdata_o)
    );

    ex_branch u_branch (
        .br_type_i(l_br_type), .pc_i(out_pc_o), .rj_data_i(l_rj_data),
        .rk_data_i(l_rk_data), .jmp_offs_i(l_jmp_offs), .ctl_valid_i(ctl_valid),
        .branch_flush_o(branch_flush_o), .jmp_addr_o(jmp_addr_o)
    );

    // live occupant is either clean or excepting
    ex_lsu u_lsu (
        .valid_i(ctl_valid | excep_o), .excep_flush_i(excep_flush_i),
        .excep_i(excep_o), .next_allowin_i(next_allowin_i), .mem_req_i(l_mem_req),
        .mem_we_i(l_mem_we), .mem_size_i(l_mem_size), .addr_i(alu_result),
        .store_data_i(l_rk_data), .mem_addr_ok_i(mem_addr_ok_i),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
        .mem_wstrb_o(mem_wstrb_o), .mem_wdata_o(mem_wdata_o), .ale_o(ale_o),
        .ready_go_o(ready_go)
    );

endmodule

// File: hw/ex_lsu.sv
// load/store address check, store formatting and request gating
`timescale 1ns/1ps
module ex_lsu
    import ex_pkg::*;
(
    input  logic      valid_i,
    input  logic      excep_flush_i,
    input  logic      excep_i,
    input  logic      next_allowin_i,
    input  logic      mem_req_i,
    input  logic      mem_we_i,
    input  mem_size_e mem_size_i,
    input  word_t     addr_i,
    input  word_t     store_data_i,
    input  logic      mem_addr_ok_i,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output word_t     mem_addr_o,
    output wstrb_t    mem_wstrb_o,
    output word_t     mem_wdata_o,
    output logic      ale_o,
    output logic      ready_go_o
);

    logic   misalign;
    logic   blocked;
    wstrb_t strb;

    always_comb begin
        case (mem_size_i)
            MEM_BYTE: misalign = 1'b0;
            MEM_HALF: misalign = addr_i[0];
            default:  misalign = |addr_i[1:0];
        endcase
    end

    assign ale_o = valid_i & ~excep_flush_i & mem_req_i & misalign;

    // byte lanes and replicated data per access size
    always_comb begin
        case (mem_size_i)
            MEM_BYTE: begin
                strb        = wstrb_t'(4'b0001 << addr_i[1:0]);
                mem_wdata_o = {4{store_data_i[7:0]}};
            end
            MEM_HALF: begin
                strb        = addr_i[1] ? 4'b1100 : 4'b0011;
                mem_wdata_o = {2{store_data_i[15:0]}};
            end
            default: begin
                strb        = 4'b1111;
                mem_wdata_o = store_data_i;
            end
        endcase
    end

    // never put a faulting address on the bus
    assign blocked = excep_i | misalign;
    assign mem_req_o = valid_i & mem_req_i & next_allowin_i & ~excep_flush_i & ~blocked;
    assign mem_we_o = mem_req_o & mem_we_i;
    assign mem_wstrb_o = mem_we_o ? strb : '0;
    assign mem_addr_o = mem_req_i ? addr_i : '0;

    // a memory op waits for addr_ok unless it is already excepting
    assign ready_go_o = ~mem_req_i | blocked | (mem_req_o & mem_addr_ok_i);

endmodule

// File: hw/ex_branch.sv
// branch condition check and jump target for the execute stage
`timescale 1ns/1ps
module ex_branch
    import ex_pkg::*;
(
    input  br_type_e br_type_i,
    input  word_t    pc_i,
    input  word_t    rj_data_i,
    input  word_t    rk_data_i,
    input  word_t    jmp_offs_i,
    input  logic     ctl_valid_i,
    output logic     branch_flush_o,
    output word_t    jmp_addr_o
);

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  taken;
    word_t base;
    word_t target;

    assign eq   = (rj_data_i == rk_data_i);
    assign lt_s = $signed(rj_data_i) < $signed(rk_data_i);
    assign lt_u = rj_data_i < rk_data_i;

    always_comb begin
        case (br_type_i)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = ~eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = ~lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = ~lt_u;
            BR_B,
            BR_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jirl jumps relative to rj, all others relative to pc
    assign base   = (br_type_i == BR_JIRL) ? rj_data_i : pc_i;
    assign target = base + jmp_offs_i;

    assign branch_flush_o = taken & ctl_valid_i;
    assign jmp_addr_o = branch_flush_o ? target : '0;

endmodule

// File: hw/ex_alu.sv
// integer ALU with multiplier and write-back value select
`timescale 1ns/1ps
module ex_alu
    import ex_pkg::*;
(
    input  alu_op_e alu_op_i,
    input  word_t   oper1_i,
    input  word_t   oper2_i,
    input  word_t   pass_data_i,
    input  wb_sel_e wb_sel_i,
    output word_t   alu_result_o,
    output word_t   regs_wdata_o
);

    logic [4:0]         shamt;
    logic               mul_signed;
    logic signed [32:0] mul_a;
    logic signed [32:0] mul_b;
    logic signed [65:0] mul_p;
    word_t              sum;
    word_t              diff;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt = oper2_i[4:0];

    // one 33x33 signed multiplier covers both mulh and mulhu
    assign mul_signed = (alu_op_i == ALU_MULH);
    assign mul_a = $signed({mul_signed & oper1_i[WORD_W-1], oper1_i});
    assign mul_b = $signed({mul_signed & oper2_i[WORD_W-1], oper2_i});
    assign mul_p = mul_a * mul_b;

    assign sum  = oper1_i + oper2_i;
    assign diff = oper1_i - oper2_i;

    assign lt_signed   = $signed(oper1_i) < $signed(oper2_i);
    assign lt_unsigned = oper1_i < oper2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:   alu_result_o = sum;
            ALU_SUB:   alu_result_o = diff;
            ALU_SLT:   alu_result_o = {{(WORD_W-1){1'b0}}, lt_signed};
            ALU_SLTU:  alu_result_o = {{(WORD_W-1){1'b0}}, lt_unsigned};
            ALU_AND:   alu_result_o = oper1_i & oper2_i;
            ALU_OR:    alu_result_o = oper1_i | oper2_i;
            ALU_NOR:   alu_result_o = ~(oper1_i | oper2_i);
            ALU_XOR:   alu_result_o = oper1_i ^ oper2_i;
            ALU_SLL:   alu_result_o = oper1_i << shamt;
            ALU_SRL:   alu_result_o = oper1_i >> shamt;
            ALU_SRA:   alu_result_o = word_t'($signed(oper1_i) >>> shamt);
            ALU_MUL:   alu_result_o = mul_p[WORD_W-1:0];
            // upper half of the 64-bit product
            ALU_MULH,
            ALU_MULHU: alu_result_o = mul_p[2*WORD_W-1:WORD_W];
            default:   alu_result_o = '0;
        endcase
    end

    // link address and similar values bypass the ALU
    assign regs_wdata_o = (wb_sel_i == WB_ALU) ? alu_result_o : pass_data_i;

endmodule

// File: hw/ex_stage_reg.sv
// execute stage latch with the valid/allowin handshake and flush
`timescale 1ns/1ps
module ex_stage_reg
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      in_valid_i,
    input  word_t     pc_i,
    input  alu_op_e   alu_op_i,
    input  word_t     oper1_i,
    input  word_t     oper2_i,
    input  word_t     pass_data_i,
    input  word_t     rj_data_i,
    input  word_t     rk_data_i,
    input  word_t     jmp_offs_i,
    input  wb_sel_e   wb_sel_i,
    input  br_type_e  br_type_i,
    input  logic      mem_req_i,
    input  logic      mem_we_i,
    input  mem_size_e mem_size_i,
    input  logic      regs_we_i,
    input  reg_addr_t regs_waddr_i,
    input  logic      excep_i,
    input  logic      excep_flush_i,
    input  logic      next_allowin_i,
    input  logic      ready_go_i,
    input  logic      ale_i,
    output logic      allowin_o,
    output logic      out_valid_o,
    output logic      ctl_valid_o,
    output word_t     pc_o,
    output alu_op_e   alu_op_o,
    output word_t     oper1_o,
    output word_t     oper2_o,
    output word_t     pass_data_o,
    output word_t     rj_data_o,
    output word_t     rk_data_o,
    output word_t     jmp_offs_o,
    output wb_sel_e   wb_sel_o,
    output br_type_e  br_type_o,
    output logic      mem_req_o,
    output logic      mem_we_o,
    output mem_size_e mem_size_o,
    output reg_addr_t regs_waddr_o,
    output logic      excep_o,
    output logic      regs_we_o
);

    logic valid_q;
    logic regs_we_q;
    logic excep_q;
    logic load;

    // no intake while write-back flushes, upstream is being killed too
    assign allowin_o = ~excep_flush_i & (~valid_q | (ready_go_i & next_allowin_i));
    assign out_valid_o = valid_q & ready_go_i & ~excep_flush_i;
    assign load = in_valid_i & allowin_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q   <= 1'b0;
            br_type_o <= BR_NONE;
            mem_req_o <= 1'b0;
            mem_we_o  <= 1'b0;
            regs_we_q <= 1'b0;
            excep_q   <= 1'b0;
        end else if (excep_flush_i) begin
            valid_q <= 1'b0;
        end else if (allowin_o) begin
            valid_q <= in_valid_i;
            if (in_valid_i) begin
                br_type_o <= br_type_i;
                mem_req_o <= mem_req_i;
                mem_we_o  <= mem_we_i;
                regs_we_q <= regs_we_i;
                excep_q   <= excep_i;
            end
        end
    end

    // operand and address payload
    always_ff @(posedge clk) begin
        if (load) begin
            pc_o         <= pc_i;
            alu_op_o     <= alu_op_i;
            oper1_o      <= oper1_i;
            oper2_o      <= oper2_i;
            pass_data_o  <= pass_data_i;
            rj_data_o    <= rj_data_i;
            rk_data_o    <= rk_data_i;
            jmp_offs_o   <= jmp_offs_i;
            wb_sel_o     <= wb_sel_i;
            mem_size_o   <= mem_size_i;
            regs_waddr_o <= regs_waddr_i;
        end
    end

    // an excepting instruction may not change architectural state
    assign ctl_valid_o = valid_q & ~excep_flush_i & ~excep_q & ~ale_i;
    assign regs_we_o = regs_we_q & ctl_valid_o;
    assign excep_o = valid_q & ~excep_flush_i & (excep_q | ale_i);

endmodule

// File: hw/ex_pkg.sv
// execute stage shared widths, vector types and operation encodings
package ex_pkg;

    localparam int WORD_W = 32;
    localparam int REG_ADDR_W = 5;
    localparam int WSTRB_W = WORD_W / 8;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [WSTRB_W-1:0]    wstrb_t;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_SLTU  = 4'd3,
        ALU_AND   = 4'd4,
        ALU_OR    = 4'd5,
        ALU_NOR   = 4'd6,
        ALU_XOR   = 4'd7,
        ALU_SLL   = 4'd8,
        ALU_SRL   = 4'd9,
        ALU_SRA   = 4'd10,
        ALU_MUL   = 4'd11,
        ALU_MULH  = 4'd12,
        ALU_MULHU = 4'd13
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_B, BR_JIRL
    } br_type_e;

    // access size, same codes as the data bus size field
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic {
        WB_PASS = 1'b0,
        WB_ALU  = 1'b1
    } wb_sel_e;

endpackage
